// File: hdl/fetch_pkg.sv
/* fetch stage shared definitions */

package fetch_pkg;

  // machine word of the rv32 core
  localparam int unsigned XPR_LEN = 32;

  // address, pc and instruction word
  typedef logic [XPR_LEN-1:0] xpr_t;

  // ahb-lite transfer type
  typedef logic [1:0] htrans_t;

  // ahb-lite burst type
  typedef logic [2:0] hburst_t;

  // ahb-lite protection control
  typedef logic [3:0] hprot_t;

  // transfer types in use
  localparam htrans_t HTRANS_IDLE   = 2'd0;
  localparam htrans_t HTRANS_NONSEQ = 2'd2;

  // fetches are single beats only
  localparam hburst_t HBURST_SINGLE = 3'd0;

  // no protection attributes on instruction reads
  localparam hprot_t HPROT_NO_PROT = 4'd0;

  // bus is never locked by the fetch stage
  localparam logic HMASTLOCK_OFF = 1'b0;

  // first fetch address out of reset
  localparam xpr_t RESET_VECTOR = 32'h8000_0000;

  // pc increment per instruction
  localparam xpr_t PC_STEP = 32'd4;

  // addi x0, x0, 0
  localparam xpr_t NOP_INST = 32'h0000_0013;

  // rom window base
  localparam xpr_t ROM_BASE = 32'h8000_0000;

  // rom window size in words
  localparam int unsigned ROM_WORDS = 64;

  // word index width inside the window
  localparam int unsigned ROM_AW = $clog2(ROM_WORDS);

  // rom window size in bytes
  localparam xpr_t ROM_SIZE = xpr_t'(ROM_WORDS * 4);

  // fetch state machine
  // st_restart waits for the bus to take a new address
  // st_fetch streams words into the hold register
  typedef enum logic {
    st_restart = 1'b0,
    st_fetch   = 1'b1
  } fetch_state_e;

endpackage

// File: hdl/fetch_unit.sv
/* instruction fetch stage */

`timescale 1ns/1ns

module fetch_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  // redirect and decode side
  input  fetch_pkg::xpr_t     pc_pif_i,
  input  logic                kill_if_i,
  input  logic                de_ready_i,
  output fetch_pkg::xpr_t     pc_if_o,
  output fetch_pkg::xpr_t     inst_if_o,
  output logic                if_valid_o,
  output logic                error_in_if_o,
  // instruction bus master
  input  logic                imem_hready_i,
  input  fetch_pkg::xpr_t     imem_hrdata_i,
  input  logic                imem_badmem_i,
  output fetch_pkg::xpr_t     imem_haddr_o,
  output fetch_pkg::htrans_t  imem_htrans_o,
  output fetch_pkg::hburst_t  imem_hburst_o,
  output logic                imem_hmastlock_o,
  output fetch_pkg::hprot_t   imem_hprot_o
);

  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  // address driven in the current address phase
  xpr_t haddr_q;
  // address whose data phase is in flight
  xpr_t last_addr_q;

  // hold register towards decode
  xpr_t pc_if_q;
  xpr_t inst_q;
  logic err_q;
  logic valid_q;

  // decode takes the held instruction this cycle
  logic take;
  // data phase finishes while the held word is stuck
  logic collide;

  assign take    = valid_q & de_ready_i;
  assign collide = imem_hready_i & valid_q & ~de_ready_i;

  // bus master outputs
  assign imem_haddr_o     = haddr_q;
  // a new word is requested in both states so the bus never idles
  assign imem_htrans_o    = HTRANS_NONSEQ;
  assign imem_hburst_o    = HBURST_SINGLE;
  assign imem_hmastlock_o = HMASTLOCK_OFF;
  assign imem_hprot_o     = HPROT_NO_PROT;

  // decode side outputs
  assign pc_if_o       = pc_if_q;
  assign inst_if_o     = inst_q;
  assign if_valid_o    = valid_q;
  assign error_in_if_o = err_q;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_restart: begin
        // leave once the bus has taken the restart address
        if (kill_if_i) begin
          state_d = st_restart;
        end else if (imem_hready_i) begin
          state_d = st_fetch;
        end
      end
      st_fetch: begin
        if (kill_if_i || collide) begin
          state_d = st_restart;
        end
      end
      default: begin
        state_d = st_restart;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= st_restart;
      haddr_q     <= RESET_VECTOR;
      last_addr_q <= RESET_VECTOR;
      pc_if_q     <= RESET_VECTOR;
      inst_q      <= NOP_INST;
      err_q       <= 1'b0;
      valid_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (kill_if_i) begin
        // redirect drops the hold register and anything in flight
        haddr_q <= pc_pif_i;
        pc_if_q <= pc_pif_i;
        inst_q  <= NOP_INST;
        err_q   <= 1'b0;
        valid_q <= 1'b0;
      end else begin
        case (state_q)
          st_restart: begin
            // data returned here belongs to a stale access and is dropped
            if (imem_hready_i) begin
              haddr_q     <= haddr_q + PC_STEP;
              last_addr_q <= haddr_q;
            end
            // held word may still leave while we restart
            if (take) begin
              valid_q <= 1'b0;
            end
          end
          st_fetch: begin
            // {memory ready, decode ready, hold valid}
            case ({imem_hready_i, de_ready_i, valid_q})
              3'b111,
              3'b110,
              3'b100: begin
                // new word fills the hold register as any old word leaves
                haddr_q     <= haddr_q + PC_STEP;
                last_addr_q <= haddr_q;
                pc_if_q     <= last_addr_q;
                inst_q      <= imem_hrdata_i;
                err_q       <= imem_badmem_i;
                valid_q     <= 1'b1;
              end
              3'b101: begin
                // nowhere to put the new word
                // throw it away and ask for it again after a restart
                // held word stays valid and untouched
                haddr_q <= last_addr_q;
              end
              3'b011: begin
                // decode drains the hold register while memory is busy
                valid_q <= 1'b0;
              end
              default: begin
                // memory busy and nothing moves towards decode
                valid_q <= valid_q;
              end
            endcase
          end
          default: begin
            valid_q <= 1'b0;
          end
        endcase
      end
    end
  end

endmodule

// File: hdl/imem_ahb.sv
/* ahb-lite instruction rom */

`timescale 1ns/1ns

module imem_ahb #(
  parameter string       INIT_FILE   = "sim/imem.hex",
  parameter int unsigned WAIT_STATES = 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // address phase
  input  fetch_pkg::xpr_t     haddr_i,
  input  fetch_pkg::htrans_t  htrans_i,
  input  fetch_pkg::hburst_t  hburst_i,
  input  logic                hmastlock_i,
  input  fetch_pkg::hprot_t   hprot_i,
  // data phase
  output fetch_pkg::xpr_t     hrdata_o,
  output logic                hready_o,
  output logic                badmem_o
);

  import fetch_pkg::*;

  // wait counter wide enough to hold WAIT_STATES
  localparam int unsigned      CNT_W     = $clog2(WAIT_STATES + 2);
  localparam logic [CNT_W-1:0] WAIT_LOAD = CNT_W'(WAIT_STATES);

  // read-only word array
  xpr_t rom_mem [ROM_WORDS];

  // captured address of the running data phase
  xpr_t addr_q;
  // a data phase is pending
  logic dphase_q;
  // remaining wait cycles
  logic [CNT_W-1:0] wait_q;

  logic              accept;
  logic              data_vld;
  logic              addr_ok;
  xpr_t              offset;
  logic [ROM_AW-1:0] word_idx;

  initial begin
    $readmemh(INIT_FILE, rom_mem);
  end

  // ready drops while wait cycles remain
  assign hready_o = (wait_q == '0);

  // only non-sequential reads start an access
  assign accept = hready_o && (htrans_i == HTRANS_NONSEQ);

  // data phase completes in the first ready cycle after the wait
  assign data_vld = dphase_q & hready_o;

  // window check on the captured address
  // addresses below the base wrap to a large offset
  assign offset   = addr_q - ROM_BASE;
  assign addr_ok  = (offset < ROM_SIZE) && (offset[1:0] == 2'b00);
  assign word_idx = offset[ROM_AW+1:2];

  // zero data and the error flag when outside the window
  assign hrdata_o = (data_vld && addr_ok) ? rom_mem[word_idx] : '0;
  assign badmem_o = data_vld & ~addr_ok;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q   <= '0;
      dphase_q <= 1'b0;
    end else begin
      if (accept) begin
        wait_q <= WAIT_LOAD;
      end else if (wait_q != '0) begin
        wait_q <= wait_q - CNT_W'(1);
      end
      // a ready cycle ends the old data phase
      // and may open the next one
      if (hready_o) begin
        dphase_q <= accept;
      end
    end
  end

  // address of each accepted transfer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= haddr_i;
    end
  end

endmodule

// File: hdl/fetch_top.sv
/* fetch stage with instruction rom */

`timescale 1ns/1ns

module fetch_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  fetch_pkg::xpr_t  pc_pif_i,
  input  logic             kill_if_i,
  input  logic             de_ready_i,
  output fetch_pkg::xpr_t  pc_if_o,
  output fetch_pkg::xpr_t  inst_if_o,
  output logic             if_valid_o,
  output logic             error_in_if_o
);

  import fetch_pkg::*;

  // internal instruction bus
  xpr_t    imem_haddr;
  htrans_t imem_htrans;
  hburst_t imem_hburst;
  logic    imem_hmastlock;
  hprot_t  imem_hprot;
  xpr_t    imem_hrdata;
  logic    imem_hready;
  logic    imem_badmem;

  fetch_unit fetch_unit_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .pc_pif_i         (pc_pif_i),
    .kill_if_i        (kill_if_i),
    .de_ready_i       (de_ready_i),
    .pc_if_o          (pc_if_o),
    .inst_if_o        (inst_if_o),
    .if_valid_o       (if_valid_o),
    .error_in_if_o    (error_in_if_o),
    .imem_hready_i    (imem_hready),
    .imem_hrdata_i    (imem_hrdata),
    .imem_badmem_i    (imem_badmem),
    .imem_haddr_o     (imem_haddr),
    .imem_htrans_o    (imem_htrans),
    .imem_hburst_o    (imem_hburst),
    .imem_hmastlock_o (imem_hmastlock),
    .imem_hprot_o     (imem_hprot)
  );

  // one wait state per access
  imem_ahb #(
    .WAIT_STATES (1)
  ) imem_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .haddr_i     (imem_haddr),
    .htrans_i    (imem_htrans),
    .hburst_i    (imem_hburst),
    .hmastlock_i (imem_hmastlock),
    .hprot_i     (imem_hprot),
    .hrdata_o    (imem_hrdata),
    .hready_o    (imem_hready),
    .badmem_o    (imem_badmem)
  );

endmodule

// File: sim/fetch_ref.svh
/* fetch reference model */

`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

// copy of the rom window contents
xpr_t ref_rom [ROM_WORDS];

// pc of the next instruction decode should accept
xpr_t exp_pc;

function automatic void load_ref_image();
  $readmemh("sim/imem.hex", ref_rom);
endfunction

// word aligned and inside the rom window
function automatic bit in_window(input xpr_t pc);
  xpr_t top;
  top = ROM_BASE + ROM_WORDS * 4;
  return (pc >= ROM_BASE) && (pc < top) && (pc[1:0] == 2'b00);
endfunction

// expected instruction and error flag for one pc
// outside the window the bus returns zero with the error set
function automatic void ref_fetch(input xpr_t pc, output xpr_t word, output logic err);
  xpr_t              offset;
  logic [ROM_AW-1:0] idx;
  offset = pc - ROM_BASE;
  idx    = offset[ROM_AW+1:2];
  if (in_window(pc)) begin
    word = ref_rom[idx];
    err  = 1'b0;
  end else begin
    word = '0;
    err  = 1'b1;
  end
endfunction

// new expected stream after a kill or reset
function automatic void track_redirect(input xpr_t target);
  exp_pc = target;
endfunction

// next sequential pc
function automatic void track_advance();
  exp_pc = exp_pc + 32'd4;
endfunction

`endif

// File: sim/fetch_tb.sv
/* fetch stage testbench */

`timescale 1ns/1ns

module fetch_tb;

  import fetch_pkg::*;

  `include "fetch_ref.svh"

  // accepted instructions over all tests with test 6 at its longest
  localparam int unsigned ACC_TOTAL = 20 + 40 + 16 + 12 + 8 + 8 * 9 + 4;
  // 20 cycles per instruction plus a margin for reset and kills
  localparam int unsigned WATCHDOG_CYCLES = ACC_TOTAL * 20 + 200;

  logic clk_i = 1'b0;
  logic rst_ni;
  xpr_t pc_pif_i;
  logic kill_if_i;
  logic de_ready_i;
  xpr_t pc_if_o;
  xpr_t inst_if_o;
  logic if_valid_o;
  logic error_in_if_o;

  integer      seed;
  int unsigned acc_cnt;
  int unsigned err_cnt;
  int unsigned test_cnt;

  // hold register as seen at the last negedge under back-pressure
  logic held_q;
  xpr_t held_pc;
  xpr_t held_inst;
  logic held_err;

  fetch_top dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pc_pif_i      (pc_pif_i),
    .kill_if_i     (kill_if_i),
    .de_ready_i    (de_ready_i),
    .pc_if_o       (pc_if_o),
    .inst_if_o     (inst_if_o),
    .if_valid_o    (if_valid_o),
    .error_in_if_o (error_in_if_o)
  );

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  // decode ready every cycle or at random until n more are accepted
  task automatic take_instructions(input int unsigned n, input bit random_ready);
    int unsigned goal;
    integer      rnd;
    goal = acc_cnt + n;
    while (acc_cnt < goal) begin
      rnd        = $random(seed);
      de_ready_i = random_ready ? rnd[0] : 1'b1;
      @(posedge clk_i);
      #1;
    end
    de_ready_i = 1'b0;
  endtask

  // one kill cycle with decode held off so nothing is taken with it
  task automatic redirect(input xpr_t target);
    pc_pif_i   = target;
    kill_if_i  = 1'b1;
    de_ready_i = 1'b0;
    @(posedge clk_i);
    #1;
    kill_if_i = 1'b0;
  endtask

  task automatic report_test(input string name, input int unsigned acc0,
                             input int unsigned err0);
    test_cnt++;
    $display("test %0d %s: %0d accepted, %0d errors", test_cnt, name,
             acc_cnt - acc0, err_cnt - err0);
  endtask

  // inputs and outputs are settled at the falling edge
  always @(negedge clk_i) begin
    xpr_t exp_word;
    logic exp_err;
    if (!rst_ni) begin
      track_redirect(RESET_VECTOR);
      held_q = 1'b0;
      if (if_valid_o !== 1'b0) begin
        $display("FAIL if_valid_o in reset got %h expected %h", if_valid_o, 1'b0);
        err_cnt++;
      end
      if (pc_if_o !== RESET_VECTOR) begin
        $display("FAIL pc_if_o in reset got %h expected %h", pc_if_o, RESET_VECTOR);
        err_cnt++;
      end
    end else begin
      // stalled word must stay put
      if (held_q) begin
        if (!if_valid_o) begin
          $display("held instruction at pc %h was dropped while decode stalled", held_pc);
          err_cnt++;
        end
        if (pc_if_o !== held_pc) begin
          $display("FAIL pc_if_o moved under stall got %h held %h", pc_if_o, held_pc);
          err_cnt++;
        end
        if (inst_if_o !== held_inst) begin
          $display("FAIL inst_if_o moved under stall got %h held %h", inst_if_o, held_inst);
          err_cnt++;
        end
        if (error_in_if_o !== held_err) begin
          $display("FAIL error_in_if_o moved under stall got %h held %h",
                   error_in_if_o, held_err);
          err_cnt++;
        end
      end
      if (kill_if_i) begin
        track_redirect(pc_pif_i);
      end else if (if_valid_o && de_ready_i) begin
        ref_fetch(exp_pc, exp_word, exp_err);
        if (pc_if_o !== exp_pc) begin
          $display("FAIL pc_if_o got %h expected %h", pc_if_o, exp_pc);
          err_cnt++;
        end
        if (inst_if_o !== exp_word) begin
          $display("FAIL inst_if_o got %h expected %h", inst_if_o, exp_word);
          err_cnt++;
        end
        if (error_in_if_o !== exp_err) begin
          $display("FAIL error_in_if_o got %h expected %h", error_in_if_o, exp_err);
          err_cnt++;
        end
        acc_cnt++;
        track_advance();
      end
      held_q    = if_valid_o && !de_ready_i && !kill_if_i;
      held_pc   = pc_if_o;
      held_inst = inst_if_o;
      held_err  = error_in_if_o;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the fetch stage stalled", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

  initial begin
    int unsigned acc0;
    int unsigned err0;
    integer      rnd;
    seed       = 41;
    rst_ni     = 1'b0;
    pc_pif_i   = '0;
    kill_if_i  = 1'b0;
    de_ready_i = 1'b0;
    acc_cnt    = 0;
    err_cnt    = 0;
    test_cnt   = 0;
    load_ref_image();
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // stream from the reset vector
    acc0 = acc_cnt;
    err0 = err_cnt;
    take_instructions(20, 1'b0);
    report_test("reset stream", acc0, err0);

    // random back-pressure
    acc0 = acc_cnt;
    err0 = err_cnt;
    take_instructions(40, 1'b1);
    report_test("random ready", acc0, err0);

    // single kill into the window
    acc0 = acc_cnt;
    err0 = err_cnt;
    redirect(ROM_BASE + 32'h40);
    take_instructions(16, 1'b1);
    report_test("kill in window", acc0, err0);

    // three kills in a row where only the last one counts
    acc0 = acc_cnt;
    err0 = err_cnt;
    redirect(ROM_BASE + 32'h10);
    redirect(ROM_BASE + 32'h80);
    redirect(ROM_BASE + 32'hc0);
    take_instructions(12, 1'b0);
    report_test("back-to-back kills", acc0, err0);

    // outside the rom window
    acc0 = acc_cnt;
    err0 = err_cnt;
    redirect(32'h0000_2000);
    take_instructions(8, 1'b1);
    report_test("kill out of window", acc0, err0);

    // random stalls and kills mixed
    acc0 = acc_cnt;
    err0 = err_cnt;
    repeat (8) begin
      rnd = $random(seed);
      take_instructions(2 + (rnd & 7), 1'b1);
      rnd = $random(seed);
      redirect(ROM_BASE + ((rnd & 63) << 2));
    end
    take_instructions(4, 1'b1);
    report_test("random kills", acc0, err0);

    $display("summary: %0d tests, %0d accepted, %0d errors",
             test_cnt, acc_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+sim
hdl/fetch_pkg.sv
hdl/fetch_unit.sv
hdl/imem_ahb.sv
hdl/fetch_top.sv
sim/fetch_tb.sv

// File: Makefile
# Verilator flow for the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= test failed

SRCS := $(wildcard hdl/*.sv sim/*.sv sim/*.svh) sim/imem.hex
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the image path inside the design is relative to this directory
run: compile
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/imem.hex
// one column: 32-bit instruction word in hex (addi x1, x1, k+1)
// line k holds the word at 0x8000_0000 + 4*k
00108093
00208093
00308093
00408093
00508093
00608093
00708093
00808093
00908093
00a08093
00b08093
00c08093
00d08093
00e08093
00f08093
01008093
01108093
01208093
01308093
01408093
01508093
01608093
01708093
01808093
01908093
01a08093
01b08093
01c08093
01d08093
01e08093
01f08093
02008093
02108093
02208093
02308093
02408093
02508093
02608093
02708093
02808093
02908093
02a08093
02b08093
02c08093
02d08093
02e08093
02f08093
03008093
03108093
03208093
03308093
03408093
03508093
03608093
03708093
03808093
03908093
03a08093
03b08093
03c08093
03d08093
03e08093
03f08093
04008093
